//--- lsu_fwd_top.f
+incdir+verification
verilog/lsu_pkt_pkg.sv
verilog/lsu_fwd_pkg.sv
verilog/lsu_fwd_ctrl.sv
verilog/lsu_lane_align.sv
verilog/lsu_rpipe_hit.sv
verilog/lsu_fwd_merge.sv
verilog/lsu_fwd_top.sv
verification/lsu_fwd_tb.sv

//--- verification/lsu_fwd_model.svh
// reference model for the store to load forwarding stage
// keeps a copy of the previous access and resolves the M access
// one byte address at a time

`ifndef LSU_FWD_MODEL_SVH
`define LSU_FWD_MODEL_SVH

// ******************************
// previous access (R stage copy)
// ******************************
lsu_pkt_pkg::lsu_pkt_t prev_pkt;
logic [ADDR_W-1:0]     prev_addr;
logic [31:0]           prev_data;

// number of bytes an access touches
function automatic int size_bytes(input lsu_pkt_pkg::access_size_t size);
  case (size)
    lsu_pkt_pkg::sz_byte: return 1;
    lsu_pkt_pkg::sz_half: return 2;
    lsu_pkt_pkg::sz_word: return 4;
    default:              return 0;
  endcase
endfunction

// only a valid store on the bus hands bytes over
function automatic logic prev_forwards();
  return prev_pkt.valid && prev_pkt.store && prev_pkt.bus_req;
endfunction

// byte offset inside the previous store or -1 when outside
function automatic int store_offset(input logic [ADDR_W-1:0] baddr);
  int n;
  int k;
  int off;
  n   = size_bytes(prev_pkt.size);
  off = -1;
  for (k = 0; k < n; k++) begin
    if (prev_addr + ADDR_W'(k) == baddr) off = k;  // store byte k sits at addr + k
  end
  return off;
endfunction

// ******************************
// expected outputs
// ******************************
function automatic lsu_fwd_pkg::fwd_result_t expected_fwd(
  input lsu_pkt_pkg::lsu_pkt_t pkt,
  input logic [ADDR_W-1:0]     addr
);
  lsu_fwd_pkg::fwd_result_t res;
  logic                     all_hit;
  int                       n;
  int                       j;
  int                       off;
  res     = '0;
  all_hit = 1'b1;
  n       = size_bytes(pkt.size);
  for (j = 0; j < n; j++) begin
    off = store_offset(addr + ADDR_W'(j));
    if (pkt.valid && pkt.bus_req && prev_forwards() && off >= 0)
      res.data[8*j +: 8] = prev_data[8*off +: 8];  // land at byte j of the load
    else
      all_hit = 1'b0;
  end
  // a side-effect load must still go out
  res.full_hit = all_hit && pkt.valid && pkt.load && pkt.bus_req && !pkt.side_effect;
  return res;
endfunction

function automatic lsu_fwd_pkg::merge_t expected_merge(
  input lsu_pkt_pkg::lsu_pkt_t pkt,
  input logic [ADDR_W-1:0]     addr
);
  lsu_fwd_pkg::merge_t res;
  logic                both_bus;
  both_bus = prev_pkt.valid && prev_pkt.bus_req && pkt.valid && pkt.bus_req;
  res.no_word_merge  = both_bus && (pkt.load || (addr >> 2) != (prev_addr >> 2));
  res.no_dword_merge = both_bus && (pkt.load || (addr >> 3) != (prev_addr >> 3));
  return res;
endfunction

function automatic logic expected_bus_req();
  return prev_pkt.valid && prev_pkt.bus_req;
endfunction

// one rising edge, reset clears the packet only
function automatic void advance_model(input logic rst, input lsu_pkt_pkg::lsu_pkt_t pkt,
                                      input logic [ADDR_W-1:0] addr, input logic [31:0] data);
  if (!rst)
    prev_pkt = '0;
  else
    prev_pkt = pkt;
  prev_addr = addr;
  prev_data = data;
endfunction

`endif

//--- verification/lsu_fwd_tb.sv
// testbench for the store to load forwarding stage
// directed and random accesses checked each cycle against a byte model

`timescale 1ns/1ps

module lsu_fwd_tb;

  localparam int                ADDR_W     = 32;
  localparam int                NUM_RANDOM = 2000;
  localparam int                MAX_CYCLES = NUM_RANDOM + 200;  // room for reset and directed
  localparam logic [ADDR_W-1:0] BASE       = 32'h0000_1000;      // 4 word window starts here

  logic                     clk;
  logic                     rst_n;
  logic                     hold_reset;
  lsu_pkt_pkg::lsu_pkt_t    m_pkt;
  logic [ADDR_W-1:0]        m_addr;
  logic [31:0]              m_store_data;
  lsu_fwd_pkg::fwd_result_t fwd;
  lsu_fwd_pkg::merge_t      merge;
  logic                     r_bus_req;
  integer                   seed = 41724;
  int                       cycles = 0;

  `include "lsu_fwd_model.svh"

  lsu_fwd_top #(.ADDR_W(ADDR_W)) DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .m_pkt        (m_pkt),
    .m_addr       (m_addr),
    .m_store_data (m_store_data),
    .fwd          (fwd),
    .merge        (merge),
    .r_bus_req    (r_bus_req)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
      fail_run($sformatf("timeout after %0d cycles without reaching the end", cycles));
  end

  // ******************************
  // failure and compare tasks
  // ******************************
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_fwd(input lsu_fwd_pkg::fwd_result_t got, exp);
    if (got !== exp)
      fail_run($sformatf("mismatch fwd got %h expected %h cycle %0d", got, exp, cycles));
  endtask

  task automatic check_merge(input lsu_fwd_pkg::merge_t got, exp);
    if (got !== exp)
      fail_run($sformatf("mismatch merge got %h expected %h cycle %0d", got, exp, cycles));
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp)
      fail_run($sformatf("mismatch %s got %h expected %h cycle %0d", name, got, exp, cycles));
  endtask

  // ******************************
  // stimulus
  // ******************************
  function automatic lsu_pkt_pkg::lsu_pkt_t make_pkt(input logic valid, load, store,
      input lsu_pkt_pkg::access_size_t size, input logic side_effect, bus_req);
    lsu_pkt_pkg::lsu_pkt_t pkt;
    pkt.valid       = valid;
    pkt.load        = load;
    pkt.store       = store;
    pkt.size        = size;
    pkt.side_effect = side_effect;
    pkt.bus_req     = bus_req;
    return pkt;
  endfunction

  function automatic lsu_pkt_pkg::lsu_pkt_t store_pkt(input lsu_pkt_pkg::access_size_t size);
    return make_pkt(1'b1, 1'b0, 1'b1, size, 1'b0, 1'b1);
  endfunction

  function automatic lsu_pkt_pkg::lsu_pkt_t load_pkt(input lsu_pkt_pkg::access_size_t size);
    return make_pkt(1'b1, 1'b1, 1'b0, size, 1'b0, 1'b1);
  endfunction

  // drive on the falling edge, compare just before the rising edge
  task automatic drive_access(input lsu_pkt_pkg::lsu_pkt_t pkt, input logic [ADDR_W-1:0] addr,
                              input logic [31:0] data);
    @(negedge clk);
    rst_n        = ~hold_reset;
    m_pkt        = pkt;
    m_addr       = addr;
    m_store_data = data;
    #2;
    check_fwd(fwd, expected_fwd(pkt, addr));
    check_merge(merge, expected_merge(pkt, addr));
    check_bit("r_bus_req", r_bus_req, expected_bus_req());
    advance_model(rst_n, pkt, addr, data);
  endtask

  task automatic random_access();
    lsu_pkt_pkg::lsu_pkt_t pkt;
    logic [31:0]           rnd;
    logic [31:0]           data;
    logic [ADDR_W-1:0]     addr;
    rnd  = $random(seed);
    data = $random(seed);
    addr = BASE + ADDR_W'(rnd[13:10]);
    pkt  = make_pkt(rnd[2:0] != 3'd0, rnd[3], ~rnd[3], lsu_pkt_pkg::sz_byte,
                    rnd[6:4] == 3'd0, rnd[9:7] != 3'd0);
    if (rnd[19:18] != 2'b11) begin  // naturally aligned
      if (rnd[15:14] == 2'd1) begin
        pkt.size = lsu_pkt_pkg::sz_half;
        addr[0]  = 1'b0;
      end else if (rnd[15:14] != 2'd0) begin
        pkt.size  = lsu_pkt_pkg::sz_word;
        addr[1:0] = 2'b00;
      end
    end else if (rnd[16]) begin
      pkt.size = lsu_pkt_pkg::sz_half;
      addr[0]  = 1'b1;
    end else begin
      pkt.size = lsu_pkt_pkg::sz_word;
      if (addr[1:0] == 2'b00) addr[0] = 1'b1;
    end
    drive_access(pkt, addr, data);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    hold_reset   = 1'b1;
    m_pkt        = '0;
    m_addr       = '0;
    m_store_data = '0;
    advance_model(rst_n, m_pkt, m_addr, m_store_data);  // edge at 4 ns

    // ******************************
    // reset over three rising edges
    // ******************************
    // stores sit in M during reset, the load after the release reads their address
    repeat (2) begin
      drive_access(store_pkt(lsu_pkt_pkg::sz_word), BASE, 32'h1234_5678);
      check_bit("r_bus_req", r_bus_req, 1'b0);
      check_bit("full_hit", fwd.full_hit, 1'b0);
      check_merge(merge, 2'b00);
    end
    hold_reset = 1'b0;
    drive_access(load_pkt(lsu_pkt_pkg::sz_word), BASE, '0);  // first cycle after reset
    check_bit("r_bus_req", r_bus_req, 1'b0);
    check_bit("full_hit", fwd.full_hit, 1'b0);
    check_merge(merge, 2'b00);

    // full forwarding
    drive_access(store_pkt(lsu_pkt_pkg::sz_word), BASE + 4, 32'ha1b2_c3d4);
    drive_access(load_pkt(lsu_pkt_pkg::sz_half), BASE + 6, '0);
    check_fwd(fwd, {1'b1, 32'h0000_a1b2});
    drive_access(store_pkt(lsu_pkt_pkg::sz_word), BASE + 4, 32'ha1b2_c3d4);
    drive_access(load_pkt(lsu_pkt_pkg::sz_word), BASE + 4, '0);
    check_fwd(fwd, {1'b1, 32'ha1b2_c3d4});

    // partial hits across a word boundary
    drive_access(store_pkt(lsu_pkt_pkg::sz_half), BASE + 3, 32'h0000_5566);
    drive_access(load_pkt(lsu_pkt_pkg::sz_word), BASE + 4, '0);
    check_fwd(fwd, {1'b0, 32'h0000_0055});
    drive_access(store_pkt(lsu_pkt_pkg::sz_word), BASE + 8, 32'h1122_3344);
    drive_access(load_pkt(lsu_pkt_pkg::sz_half), BASE + 7, '0);
    check_fwd(fwd, {1'b0, 32'h0000_4400});

    // R is a load, off the bus, invalid
    drive_access(load_pkt(lsu_pkt_pkg::sz_word), BASE, '0);
    drive_access(load_pkt(lsu_pkt_pkg::sz_word), BASE, '0);
    check_fwd(fwd, '0);
    drive_access(make_pkt(1'b1, 1'b0, 1'b1, lsu_pkt_pkg::sz_word, 1'b0, 1'b0), BASE, '1);
    drive_access(load_pkt(lsu_pkt_pkg::sz_word), BASE, '0);
    check_fwd(fwd, '0);
    drive_access(make_pkt(1'b0, 1'b0, 1'b1, lsu_pkt_pkg::sz_word, 1'b0, 1'b1), BASE, '1);
    drive_access(load_pkt(lsu_pkt_pkg::sz_word), BASE, '0);
    check_fwd(fwd, '0);
    drive_access(store_pkt(lsu_pkt_pkg::sz_word), BASE, 32'hdead_beef);
    drive_access(make_pkt(1'b1, 1'b1, 1'b0, lsu_pkt_pkg::sz_word, 1'b1, 1'b1), BASE, '0);
    check_fwd(fwd, {1'b0, 32'hdead_beef});  // side effect keeps data

    // coalescing decisions
    drive_access(store_pkt(lsu_pkt_pkg::sz_word), BASE, '1);
    drive_access(store_pkt(lsu_pkt_pkg::sz_half), BASE + 2, '1);
    check_merge(merge, 2'b00);
    drive_access(store_pkt(lsu_pkt_pkg::sz_word), BASE + 4, '1);
    check_merge(merge, 2'b10);
    drive_access(store_pkt(lsu_pkt_pkg::sz_word), BASE + 8, '1);
    check_merge(merge, 2'b11);
    drive_access(load_pkt(lsu_pkt_pkg::sz_word), BASE + 8, '0);
    check_merge(merge, 2'b11);

    repeat (NUM_RANDOM) random_access();

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- verilog/lsu_fwd_top.sv
// store to load forwarding top
// R stage registers and merge decisions in the control block,
// lane alignment, hit detection and data merge in the datapath

`timescale 1ns/1ps

module lsu_fwd_top #(
  parameter int ADDR_W = 32
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  lsu_pkt_pkg::lsu_pkt_t    m_pkt,
  input  logic [ADDR_W-1:0]        m_addr,
  input  logic [31:0]              m_store_data,
  output lsu_fwd_pkg::fwd_result_t fwd,
  output lsu_fwd_pkg::merge_t      merge,
  output logic                     r_bus_req
);

  lsu_pkt_pkg::lsu_pkt_t r_pkt;
  logic [ADDR_W-1:0]     r_addr;
  logic [31:0]           r_store_data;
  lsu_fwd_pkg::lane_be_t m_be;
  lsu_fwd_pkg::lane_be_t r_be;
  logic [ADDR_W-3:0]     m_end_word;
  logic [ADDR_W-3:0]     r_end_word;
  lsu_fwd_pkg::lane_be_t hit_be;
  logic [63:0]           lane_data;  // {hi lane, lo lane} forwarded bytes

  // ******************************
  // control
  // ******************************
  lsu_fwd_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .m_pkt        (m_pkt),
    .m_addr       (m_addr),
    .m_store_data (m_store_data),
    .r_pkt        (r_pkt),
    .r_addr       (r_addr),
    .r_store_data (r_store_data),
    .r_bus_req    (r_bus_req),
    .merge        (merge)
  );

  // ******************************
  // datapath
  // ******************************
  lsu_lane_align #(.ADDR_W(ADDR_W)) m_align (
    .pkt      (m_pkt),
    .addr     (m_addr),
    .be       (m_be),
    .end_word (m_end_word)
  );

  lsu_lane_align #(.ADDR_W(ADDR_W)) r_align (
    .pkt      (r_pkt),
    .addr     (r_addr),
    .be       (r_be),
    .end_word (r_end_word)
  );

  lsu_rpipe_hit #(.ADDR_W(ADDR_W)) u_hit (
    .m_pkt        (m_pkt),
    .m_addr       (m_addr),
    .m_be         (m_be),
    .m_end_word   (m_end_word),
    .r_pkt        (r_pkt),
    .r_addr       (r_addr),
    .r_be         (r_be),
    .r_end_word   (r_end_word),
    .r_store_data (r_store_data),
    .hit_be       (hit_be),
    .lane_data    (lane_data)
  );

  lsu_fwd_merge #(.ADDR_W(ADDR_W)) u_merge (
    .m_pkt     (m_pkt),
    .m_addr    (m_addr),
    .m_be      (m_be),
    .hit_be    (hit_be),
    .lane_data (lane_data),
    .fwd       (fwd)
  );

endmodule

//--- verilog/lsu_fwd_merge.sv
// forward merge
// decides whether the M load is fully covered by the R store
// and shifts the forwarded lanes down to byte 0 of the load result

`timescale 1ns/1ps

module lsu_fwd_merge #(
  parameter int ADDR_W = 32
) (
  input  lsu_pkt_pkg::lsu_pkt_t  m_pkt,
  input  logic [ADDR_W-1:0]      m_addr,
  input  lsu_fwd_pkg::lane_be_t  m_be,
  input  lsu_fwd_pkg::lane_be_t  hit_be,
  input  logic [63:0]            lane_data,
  output lsu_fwd_pkg::fwd_result_t fwd
);

  logic        lo_covered;  // every enabled lo byte was hit
  logic        hi_covered;
  logic        fwd_load;    // load that may use forwarded data
  logic [63:0] data_shift;

  // ******************************
  // full hit
  // ******************************
  assign lo_covered = &(hit_be.lo | ~m_be.lo);
  assign hi_covered = &(hit_be.hi | ~m_be.hi);

  // a side-effect load has to see the bus, never a full hit
  assign fwd_load = m_pkt.valid & m_pkt.load & m_pkt.bus_req & ~m_pkt.side_effect;

  assign fwd.full_hit = lo_covered & hi_covered & fwd_load;

  // ******************************
  // load data alignment
  // ******************************
  assign data_shift = lane_data >> {m_addr[1:0], 3'b000};
  assign fwd.data   = data_shift[31:0];

endmodule

//--- verilog/lsu_rpipe_hit.sv
// R pipe hit detection
// compares the M access against the R store on all four lane pairs
// and collects the store bytes that the M access can take

`timescale 1ns/1ps

module lsu_rpipe_hit #(
  parameter int ADDR_W = 32
) (
  input  lsu_pkt_pkg::lsu_pkt_t m_pkt,
  input  logic [ADDR_W-1:0]     m_addr,
  input  lsu_fwd_pkg::lane_be_t m_be,
  input  logic [ADDR_W-3:0]     m_end_word,
  input  lsu_pkt_pkg::lsu_pkt_t r_pkt,
  input  logic [ADDR_W-1:0]     r_addr,
  input  lsu_fwd_pkg::lane_be_t r_be,
  input  logic [ADDR_W-3:0]     r_end_word,
  input  logic [31:0]           r_store_data,
  output lsu_fwd_pkg::lane_be_t hit_be,
  output logic [63:0]           lane_data
);

  localparam int BPW = lsu_pkt_pkg::BYTES_PER_WORD;

  logic           fwd_qual;  // R can forward to M at all
  // word hits, named <r lane>_<m lane>
  logic           hit_lo_lo;
  logic           hit_lo_hi;
  logic           hit_hi_lo;
  logic           hit_hi_hi;
  logic [BPW-1:0] byte_lo_lo;
  logic [BPW-1:0] byte_lo_hi;
  logic [BPW-1:0] byte_hi_lo;
  logic [BPW-1:0] byte_hi_hi;
  logic [63:0]    store_ext;  // store data placed at its byte offset
  logic [31:0]    store_lo;
  logic [31:0]    store_hi;

  // M enables are already zero for an invalid access
  assign fwd_qual = r_pkt.valid & r_pkt.store & r_pkt.bus_req & m_pkt.bus_req;

  // ******************************
  // word address compare
  // ******************************
  assign hit_lo_lo = fwd_qual & (r_addr[ADDR_W-1:2] == m_addr[ADDR_W-1:2]);
  assign hit_lo_hi = fwd_qual & (r_addr[ADDR_W-1:2] == m_end_word);
  assign hit_hi_lo = fwd_qual & (r_end_word == m_addr[ADDR_W-1:2]);
  assign hit_hi_hi = fwd_qual & (r_end_word == m_end_word);

  assign store_ext = {32'b0, r_store_data} << {r_addr[1:0], 3'b000};
  assign store_lo  = store_ext[31:0];
  assign store_hi  = store_ext[63:32];

  // ******************************
  // per byte hits and data
  // ******************************
  for (genvar i = 0; i < BPW; i++) begin : g_byte
    assign byte_lo_lo[i] = hit_lo_lo & r_be.lo[i] & m_be.lo[i];
    assign byte_lo_hi[i] = hit_lo_hi & r_be.lo[i] & m_be.hi[i];
    assign byte_hi_lo[i] = hit_hi_lo & r_be.hi[i] & m_be.lo[i];
    assign byte_hi_hi[i] = hit_hi_hi & r_be.hi[i] & m_be.hi[i];

    assign hit_be.lo[i] = byte_lo_lo[i] | byte_hi_lo[i];
    assign hit_be.hi[i] = byte_lo_hi[i] | byte_hi_hi[i];

    // at most one term per byte is live, bytes without a hit read zero
    assign lane_data[8*i +: 8] = ({8{byte_lo_lo[i]}} & store_lo[8*i +: 8]) |
                                 ({8{byte_hi_lo[i]}} & store_hi[8*i +: 8]);
    assign lane_data[32 + 8*i +: 8] = ({8{byte_lo_hi[i]}} & store_lo[8*i +: 8]) |
                                      ({8{byte_hi_hi[i]}} & store_hi[8*i +: 8]);
  end

endmodule

//--- verilog/lsu_lane_align.sv
// lane alignment
// turns access size and byte address into byte enables split over
// the start word and the end word, plus the word address of the last byte

`timescale 1ns/1ps

module lsu_lane_align #(
  parameter int ADDR_W = 32
) (
  input  lsu_pkt_pkg::lsu_pkt_t pkt,
  input  logic [ADDR_W-1:0]     addr,
  output lsu_fwd_pkg::lane_be_t be,
  output logic [ADDR_W-3:0]     end_word
);

  localparam int BPW = lsu_pkt_pkg::BYTES_PER_WORD;

  logic [BPW-1:0]    be_raw;    // enables before the address shift
  logic [1:0]        last_off;  // offset of the last byte from the first
  logic [2*BPW-1:0]  be_ext;    // enables spread over both lanes
  logic [ADDR_W-1:0] end_addr;

  always_comb begin
    be_raw   = '0;
    last_off = 2'd0;
    case (pkt.size)
      lsu_pkt_pkg::sz_byte: begin
        be_raw   = 4'b0001;
        last_off = 2'd0;
      end
      lsu_pkt_pkg::sz_half: begin
        be_raw   = 4'b0011;
        last_off = 2'd1;
      end
      lsu_pkt_pkg::sz_word: begin
        be_raw   = 4'b1111;
        last_off = 2'd3;
      end
      default: ;  // unused encoding enables nothing
    endcase
  end

  assign be_ext = {{BPW{1'b0}}, be_raw & {BPW{pkt.valid}}} << addr[1:0];
  assign be.lo  = be_ext[BPW-1:0];
  assign be.hi  = be_ext[2*BPW-1:BPW];

  // word of the last byte, differs from addr only on a crossing access
  assign end_addr = addr + ADDR_W'(last_off);
  assign end_word = end_addr[ADDR_W-1:2];

endmodule

//--- verilog/lsu_fwd_ctrl.sv
// forwarding control
// holds the R stage copy of the M access and decides whether the
// R store may coalesce with the M access at word and doubleword level

`timescale 1ns/1ps

module lsu_fwd_ctrl #(
  parameter int ADDR_W = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  lsu_pkt_pkg::lsu_pkt_t m_pkt,
  input  logic [ADDR_W-1:0]     m_addr,
  input  logic [31:0]           m_store_data,
  output lsu_pkt_pkg::lsu_pkt_t r_pkt,
  output logic [ADDR_W-1:0]     r_addr,
  output logic [31:0]           r_store_data,
  output logic                  r_bus_req,
  output lsu_fwd_pkg::merge_t   merge
);

  logic m_bus_req;     // valid bus access in M
  logic word_match;    // same word address in M and R
  logic dword_match;   // same doubleword address in M and R
  logic merge_block;   // both stages on the bus, so a decision is needed

  // ******************************
  // R stage registers
  // ******************************
  // only the attributes are cleared; address and data follow the packet
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_pkt <= '0;
    end else begin
      r_pkt <= m_pkt;
    end
  end

  always_ff @(posedge clk) begin
    r_addr       <= m_addr;
    r_store_data <= m_store_data;
  end

  // ******************************
  // coalescing decisions
  // ******************************
  assign m_bus_req = m_pkt.valid & m_pkt.bus_req;
  assign r_bus_req = r_pkt.valid & r_pkt.bus_req;

  assign dword_match = (r_addr[ADDR_W-1:3] == m_addr[ADDR_W-1:3]);
  assign word_match  = dword_match & (r_addr[2] == m_addr[2]);  // narrow the dword compare

  assign merge_block = r_bus_req & m_bus_req;

  // a younger load always breaks the merge, as does a different address
  assign merge.no_word_merge  = merge_block & (m_pkt.load | ~word_match);
  assign merge.no_dword_merge = merge_block & (m_pkt.load | ~dword_match);

endmodule

//--- verilog/lsu_fwd_pkg.sv
// forwarding result definitions
// lane byte enables, the forward answer for the load in M
// and the coalescing decision for the store in R

package lsu_fwd_pkg;

  // ******************************
  // lane byte enables
  // ******************************
  // lo is the word holding the first byte, hi the word holding the last;
  // hi stays zero unless the access crosses a word boundary
  typedef struct packed {
    logic [lsu_pkt_pkg::BYTES_PER_WORD-1:0] hi;
    logic [lsu_pkt_pkg::BYTES_PER_WORD-1:0] lo;
  } lane_be_t;

  // ******************************
  // forward answer for the M load
  // ******************************
  typedef struct packed {
    logic        full_hit;  // every needed byte came from R
    logic [31:0] data;      // forwarded bytes aligned to byte 0
  } fwd_result_t;

  // ******************************
  // coalescing decision
  // ******************************
  typedef struct packed {
    logic no_word_merge;   // R store cannot merge with M within a word
    logic no_dword_merge;  // same at doubleword granularity
  } merge_t;

endpackage

//--- verilog/lsu_pkt_pkg.sv
// lsu access packet definitions
// size encoding and the attribute bits that travel with every access
// through the M and R stages of the bus path

package lsu_pkt_pkg;

  // ******************************
  // basic geometry
  // ******************************
  localparam int BYTES_PER_WORD = 4;  // bytes in one bus word

  // ******************************
  // access size
  // ******************************
  typedef enum logic [1:0] {
    sz_byte = 2'b00,  // 1 byte
    sz_half = 2'b01,  // 2 bytes
    sz_word = 2'b10   // 4 bytes
  } access_size_t;

  // ******************************
  // access attributes
  // ******************************
  // bus_req marks an access that goes out to the external bus;
  // side_effect marks a region where loads must not be satisfied early
  typedef struct packed {
    logic         valid;        // access present in this stage
    logic         load;
    logic         store;
    access_size_t size;
    logic         side_effect;  // no speculative read allowed
    logic         bus_req;      // targets the external bus
  } lsu_pkt_t;

endpackage
